// ==== all.f ====
+incdir+common
common/video_pkg.sv
common/tetris_pkg.sv
common/pixel_if.sv
playfield/playfield_layer.sv
piece/piece_layer.sv
score/score_layer.sv
design/color_compositor.sv
design/pixel_color_top.sv
tests/tb_pixel_model.sv
tests/tb_pixel_color.sv

// ==== common/pixel_if.sv ====
// Pixel request bundle from the top level to the layers and the compositor
`timescale 1ns/100ps

interface pixel_if import video_pkg::*; ();

    logic        pixel_valid;
    coord_t      draw_x;
    coord_t      draw_y;
    game_state_e game_state;

    modport source (output pixel_valid, draw_x, draw_y, game_state);
    modport sink   (input  pixel_valid, draw_x, draw_y, game_state);

endinterface

// ==== common/tetris_defs.svh ====
// Tetris screen geometry, font scale and palette constants for the color mapper
`ifndef TETRIS_DEFS_SVH
`define TETRIS_DEFS_SVH

// ------------------------------
// Playfield geometry
// ------------------------------
`define BOARD_X0      250
`define BOARD_Y0      100
`define CELL_SIZE     16
`define CELL_SHIFT    4           // log2 of the cell size
`define BOARD_COLS    10
`define BOARD_ROWS    20
`define BOARD_CELLS   (`BOARD_COLS * `BOARD_ROWS)
`define BOARD_W       (`BOARD_COLS * `CELL_SIZE)
`define BOARD_H       (`BOARD_ROWS * `CELL_SIZE)

// Falling piece spans a 4x4 cell box
`define PIECE_SPAN    (4 * `CELL_SIZE)

// ------------------------------
// Score digits
// ------------------------------
`define SCORE_X0      492
`define SCORE_X1      516
`define SCORE_X2      540
`define SCORE_X3      564
`define SCORE_Y       75
`define FONT_CELLS    5
`define FONT_SHIFT    2           // Font cells are 4 pixels square
`define DIGIT_SIZE    (`FONT_CELLS * 4)
`define DIGIT_PAL     9

`endif

// ==== common/tetris_pkg.sv ====
// Game object types for the falling piece, the playfield cells and the score
package tetris_pkg;

    // Piece shape codes, also used as their palette index
    typedef enum logic [2:0] {
        shape_none = 3'd0,
        shape_i    = 3'd1,
        shape_o    = 3'd2,
        shape_j    = 3'd3,
        shape_l    = 3'd4,
        shape_s    = 3'd5,
        shape_t    = 3'd6,
        shape_z    = 3'd7
    } shape_e;

    typedef logic [1:0] rotation_t;   // Quarter turns

    // Playfield cell address
    typedef logic [4:0] cell_row_t;   // 0 to 19
    typedef logic [3:0] cell_col_t;   // 0 to 9

    typedef logic [3:0] digit_t;      // Decimal score digit

endpackage

// ==== common/video_pkg.sv ====
// Video stream types for screen coordinates, color channels and game state
package video_pkg;

    typedef logic [9:0] coord_t;    // Screen coordinate in pixels
    typedef logic [7:0] chan_t;     // One RGB channel
    typedef logic [3:0] pal_idx_t;  // Palette index with 0 as transparent

    // Game state as seen by the display
    typedef enum logic [1:0] {
        gs_play     = 2'd0,
        gs_idle     = 2'd1,
        gs_play_alt = 2'd2,
        gs_over     = 2'd3
    } game_state_e;

endpackage

// ==== design/color_compositor.sv ====
// Layer merge, palette lookup and background gradient with registered RGB out
`timescale 1ns/100ps
`include "tetris_defs.svh"

module color_compositor
    import video_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    pixel_if.sink    pix,
    input  logic     field_hit,
    input  pal_idx_t field_color,
    input  logic     piece_hit,
    input  pal_idx_t piece_color,
    input  logic     score_hit,
    input  pal_idx_t score_color,
    output logic     rgb_valid,
    output chan_t    red,
    output chan_t    green,
    output chan_t    blue
);

    logic        valid_q;
    coord_t      x_q;
    game_state_e state_q;
    logic        in_board_q;
    chan_t       grad;
    pal_idx_t    layer_pal;
    logic [23:0] bg_rgb;
    logic [23:0] pix_rgb;

    function automatic logic [23:0] pal_rgb(input pal_idx_t idx);
        case (idx)
            4'd1:       return 24'h00FFFF;  // Cyan
            4'd2:       return 24'hFFFF00;  // Yellow
            4'd3:       return 24'h0000FF;  // Blue
            4'd4:       return 24'hFFA500;  // Orange
            4'd5:       return 24'h00FF00;  // Green
            4'd6:       return 24'hFF0000;  // Red
            4'd7:       return 24'h8A2BE2;  // Purple
            4'd8, 4'd9: return 24'hFFFFFF;
            default:    return 24'h000000;
        endcase
    endfunction

    // ------------------------------
    // Stage 1 copy of the pixel
    // ------------------------------
    always_ff @(posedge clk)
    begin
        x_q        <= pix.draw_x;
        state_q    <= pix.game_state;
        in_board_q <= (pix.draw_x - coord_t'(`BOARD_X0) < coord_t'(`BOARD_W))
                   && (pix.draw_y - coord_t'(`BOARD_Y0) < coord_t'(`BOARD_H));
    end

    assign grad = chan_t'(x_q >> 3);    // One step per 8 pixels

    always_comb
    begin
        if (state_q == gs_idle)
            bg_rgb = {8'h09 + grad, 8'h04 + grad, 8'h6A + grad};
        else if (in_board_q)
            bg_rgb = {8'h69 - grad, 8'h69 - grad, 8'h69 - grad};  // Gray board
        else
            bg_rgb = {8'h00, 8'h47, 8'hAB - (grad << 1)};
    end

    // Playfield over piece over score
    always_comb
    begin
        layer_pal = '0;
        if (field_hit)
            layer_pal = field_color;
        else if (piece_hit)
            layer_pal = piece_color;
        else if (score_hit)
            layer_pal = score_color;
    end

    assign pix_rgb = ((state_q != gs_idle) && (layer_pal != '0)) ? pal_rgb(layer_pal) : bg_rgb;

    // ------------------------------
    // Output stage
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q   <= 1'b0;
            rgb_valid <= 1'b0;
        end
        else
        begin
            valid_q   <= pix.pixel_valid;
            rgb_valid <= valid_q;
        end
    end

    always_ff @(posedge clk)
    begin
        {red, green, blue} <= pix_rgb;
    end

    valid_after_reset_a: assert property (@(posedge clk) $fell(reset) |=> !rgb_valid);

endmodule

// ==== design/pixel_color_top.sv ====
// Pipelined Tetris pixel color mapper with playfield, piece and score layers
`timescale 1ns/100ps

module pixel_color_top
    import video_pkg::*;
    import tetris_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pixel_valid,
    input  coord_t      draw_x,
    input  coord_t      draw_y,
    input  game_state_e game_state,
    input  shape_e      piece_shape,
    input  rotation_t   piece_rotation,
    input  coord_t      piece_x,
    input  coord_t      piece_y,
    input  digit_t      score_thousands,
    input  digit_t      score_hundreds,
    input  digit_t      score_tens,
    input  digit_t      score_ones,
    input  logic        cell_we,
    input  cell_row_t   cell_row,
    input  cell_col_t   cell_col,
    input  pal_idx_t    cell_color,
    output logic        rgb_valid,
    output chan_t       red,
    output chan_t       green,
    output chan_t       blue
);

    logic     field_hit;
    pal_idx_t field_color;
    logic     piece_hit;
    pal_idx_t piece_color;
    logic     score_hit;
    pal_idx_t score_color;

    // Pixel request fans out to every stage
    pixel_if pix ();

    assign pix.pixel_valid = pixel_valid;
    assign pix.draw_x      = draw_x;
    assign pix.draw_y      = draw_y;
    assign pix.game_state  = game_state;

    playfield_layer playfield_layer_i (
        .clk        (clk),
        .reset      (reset),
        .pix        (pix),
        .cell_we    (cell_we),
        .cell_row   (cell_row),
        .cell_col   (cell_col),
        .cell_color (cell_color),
        .hit        (field_hit),
        .color      (field_color)
    );

    piece_layer piece_layer_i (
        .clk            (clk),
        .pix            (pix),
        .piece_shape    (piece_shape),
        .piece_rotation (piece_rotation),
        .piece_x        (piece_x),
        .piece_y        (piece_y),
        .hit            (piece_hit),
        .color          (piece_color)
    );

    score_layer score_layer_i (
        .clk             (clk),
        .pix             (pix),
        .score_thousands (score_thousands),
        .score_hundreds  (score_hundreds),
        .score_tens      (score_tens),
        .score_ones      (score_ones),
        .hit             (score_hit),
        .color           (score_color)
    );

    color_compositor color_compositor_i (
        .clk         (clk),
        .reset       (reset),
        .pix         (pix),
        .field_hit   (field_hit),
        .field_color (field_color),
        .piece_hit   (piece_hit),
        .piece_color (piece_color),
        .score_hit   (score_hit),
        .score_color (score_color),
        .rgb_valid   (rgb_valid),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

endmodule

// ==== piece/piece_layer.sv ====
// Falling piece layer with the shape mask table and its hit test
`timescale 1ns/100ps
`include "tetris_defs.svh"

module piece_layer
    import video_pkg::*;
    import tetris_pkg::*;
(
    input  logic      clk,
    pixel_if.sink     pix,
    input  shape_e    piece_shape,
    input  rotation_t piece_rotation,
    input  coord_t    piece_x,
    input  coord_t    piece_y,
    output logic      hit,
    output pal_idx_t  color
);

    coord_t      off_x;
    coord_t      off_y;
    logic        in_box;
    logic [1:0]  mask_row;
    logic [1:0]  mask_col;
    logic [15:0] mask;

    // 4x4 mask read row 0 first, column 0 leftmost
    function automatic logic [15:0] piece_mask(input shape_e shape, input rotation_t rot);
        logic [15:0] m;
        m = '0;
        case (shape)
            shape_i: m = rot[0] ? 16'b1000_1000_1000_1000 : 16'b1111_0000_0000_0000;
            shape_o: m = 16'b1100_1100_0000_0000;
            shape_j:
                case (rot)
                    2'd0: m = 16'b1000_1110_0000_0000;
                    2'd1: m = 16'b1100_1000_1000_0000;
                    2'd2: m = 16'b1110_0010_0000_0000;
                    2'd3: m = 16'b0100_0100_1100_0000;
                endcase
            shape_l:
                case (rot)
                    2'd0: m = 16'b0010_1110_0000_0000;
                    2'd1: m = 16'b1000_1000_1100_0000;
                    2'd2: m = 16'b1110_1000_0000_0000;
                    2'd3: m = 16'b1100_0100_0100_0000;
                endcase
            shape_s: m = rot[0] ? 16'b1000_1100_0100_0000 : 16'b0110_1100_0000_0000;
            shape_t:
                case (rot)
                    2'd0: m = 16'b0100_1110_0000_0000;
                    2'd1: m = 16'b1000_1100_1000_0000;
                    2'd2: m = 16'b1110_0100_0000_0000;
                    2'd3: m = 16'b0100_1100_0100_0000;
                endcase
            shape_z: m = rot[0] ? 16'b0100_1100_1000_0000 : 16'b1100_0110_0000_0000;
            default: m = '0;
        endcase
        return m;
    endfunction

    // Offsets wrap above and left of the origin, so one compare per axis
    assign off_x    = pix.draw_x - piece_x;
    assign off_y    = pix.draw_y - piece_y;
    assign in_box   = (off_x < coord_t'(`PIECE_SPAN)) && (off_y < coord_t'(`PIECE_SPAN));
    assign mask_row = 2'(off_y >> `CELL_SHIFT);
    assign mask_col = 2'(off_x >> `CELL_SHIFT);
    assign mask     = piece_mask(piece_shape, piece_rotation);

    // ------------------------------
    // Layer output register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        hit   <= in_box && (piece_shape != shape_none)
                        && mask[4'd15 - {mask_row, mask_col}];
        color <= pal_idx_t'({1'b0, piece_shape});  // Shape code picks the color
    end

endmodule

// ==== playfield/playfield_layer.sv ====
// Settled playfield layer with the cell memory and its flat cell color lookup
`timescale 1ns/100ps
`include "tetris_defs.svh"

module playfield_layer
    import video_pkg::*;
    import tetris_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    pixel_if.sink     pix,
    input  logic      cell_we,
    input  cell_row_t cell_row,
    input  cell_col_t cell_col,
    input  pal_idx_t  cell_color,
    output logic      hit,
    output pal_idx_t  color
);

    pal_idx_t   cells [`BOARD_CELLS];   // Row major, 10 cells per row
    coord_t     off_x;
    coord_t     off_y;
    logic       in_board;
    cell_row_t  rd_row;
    cell_col_t  rd_col;
    logic [7:0] rd_addr;
    logic       wr_ok;

    function automatic logic [7:0] cell_index(input cell_row_t row, input cell_col_t col);
        return 8'(row) * 8'(`BOARD_COLS) + 8'(col);
    endfunction

    // Pixel to cell address
    assign off_x    = pix.draw_x - coord_t'(`BOARD_X0);
    assign off_y    = pix.draw_y - coord_t'(`BOARD_Y0);
    assign in_board = (off_x < coord_t'(`BOARD_W)) && (off_y < coord_t'(`BOARD_H));
    assign rd_row   = cell_row_t'(off_y >> `CELL_SHIFT);
    assign rd_col   = cell_col_t'(off_x >> `CELL_SHIFT);
    assign rd_addr  = cell_index(rd_row, rd_col);

    assign wr_ok = cell_we && (cell_row < cell_row_t'(`BOARD_ROWS))
                           && (cell_col < cell_col_t'(`BOARD_COLS));

    // ------------------------------
    // Cell memory
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `BOARD_CELLS; i++)
                cells[i] <= '0;     // Empty board
        end
        else if (wr_ok)
            cells[cell_index(cell_row, cell_col)] <= cell_color;
    end

    // Synchronous read, old data on a same-cycle write
    always_ff @(posedge clk)
    begin
        if (in_board)
        begin
            hit   <= (cells[rd_addr] != '0);
            color <= cells[rd_addr];
        end
        else
        begin
            hit   <= 1'b0;
            color <= '0;
        end
    end

    write_in_board_a: assert property (@(posedge clk) disable iff (reset)
        cell_we |-> (cell_row < cell_row_t'(`BOARD_ROWS)) && (cell_col < cell_col_t'(`BOARD_COLS)));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pixel color mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f all.f --top-module tb_pixel_color
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_pixel_color)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== score/score_layer.sv ====
// Score layer drawing four decimal digits from a 5x5 font
`timescale 1ns/100ps
`include "tetris_defs.svh"

module score_layer
    import video_pkg::*;
    import tetris_pkg::*;
(
    input  logic     clk,
    pixel_if.sink    pix,
    input  digit_t   score_thousands,
    input  digit_t   score_hundreds,
    input  digit_t   score_tens,
    input  digit_t   score_ones,
    output logic     hit,
    output pal_idx_t color
);

    localparam coord_t DIGIT_X [4] = '{coord_t'(`SCORE_X0), coord_t'(`SCORE_X1),
                                       coord_t'(`SCORE_X2), coord_t'(`SCORE_X3)};

    digit_t      digits [4];
    coord_t      off_y;
    logic        in_row;
    logic        in_field;
    digit_t      digit_sel;
    coord_t      field_x;
    logic [2:0]  font_row;
    logic [2:0]  font_col;
    logic [24:0] glyph;

    // Glyph rows top first, leftmost column as the first bit of each row
    function automatic logic [24:0] digit_font(input digit_t d);
        case (d)
            4'd0:    return 25'b11111_10001_10001_10001_11111;
            4'd1:    return 25'b00100_00100_00100_00100_00100;
            4'd2:    return 25'b11111_00001_11111_10000_11111;
            4'd3:    return 25'b11111_00001_11111_00001_11111;
            4'd4:    return 25'b10001_10001_11111_00001_00001;
            4'd5:    return 25'b11111_10000_11111_00001_11111;
            4'd6:    return 25'b11111_10000_11111_10001_11111;
            4'd7:    return 25'b11111_00001_00001_00001_00001;
            4'd8:    return 25'b11111_10001_11111_10001_11111;
            4'd9:    return 25'b11111_10001_11111_00001_11111;
            default: return '0;
        endcase
    endfunction

    assign digits[0] = score_thousands;
    assign digits[1] = score_hundreds;
    assign digits[2] = score_tens;
    assign digits[3] = score_ones;

    assign off_y  = pix.draw_y - coord_t'(`SCORE_Y);
    assign in_row = off_y < coord_t'(`DIGIT_SIZE);

    // Digit field under the pixel, the fields never overlap
    always_comb
    begin
        coord_t off_x;
        in_field  = 1'b0;
        digit_sel = '0;
        field_x   = '0;
        for (int k = 0; k < 4; k++)
        begin
            off_x = pix.draw_x - DIGIT_X[k];
            if (in_row && (off_x < coord_t'(`DIGIT_SIZE)))
            begin
                in_field  = 1'b1;
                digit_sel = digits[k];
                field_x   = off_x;
            end
        end
    end

    assign font_row = 3'(off_y >> `FONT_SHIFT);
    assign font_col = 3'(field_x >> `FONT_SHIFT);
    assign glyph    = digit_font(digit_sel);

    always_ff @(posedge clk)
    begin
        hit   <= in_field && glyph[5'd24 - (5'(font_row) * 5'd5 + 5'(font_col))];
        color <= pal_idx_t'(`DIGIT_PAL);   // White digits
    end

    digit_range_a: assert property (@(posedge clk)
        pix.pixel_valid |-> (score_thousands <= 4'd9) && (score_hundreds <= 4'd9)
                         && (score_tens <= 4'd9) && (score_ones <= 4'd9));

endmodule

// ==== tests/tb_pixel_color.sv ====
// Testbench top driving directed and random pixel streams into the color mapper
`timescale 1ns/100ps

module tb_pixel_color
    import video_pkg::*;
    import tetris_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        pixel_valid;
    coord_t      draw_x;
    coord_t      draw_y;
    game_state_e game_state;
    shape_e      piece_shape;
    rotation_t   piece_rotation;
    coord_t      piece_x;
    coord_t      piece_y;
    digit_t      score_thousands;
    digit_t      score_hundreds;
    digit_t      score_tens;
    digit_t      score_ones;
    logic        cell_we;
    cell_row_t   cell_row;
    cell_col_t   cell_col;
    pal_idx_t    cell_color;
    logic        rgb_valid;
    chan_t       red;
    chan_t       green;
    chan_t       blue;
    int          error_count;
    int          check_count;
    int          seed = 60;
    int          tests_run = 0;
    int          errors_before = 0;
    bit          timed_out = 1'b0;
    int          edge_x [4] = '{249, 250, 409, 410};   // Board borders
    int          edge_y [4] = '{99, 100, 419, 420};

    pixel_color_top pixel_color_top_i (.*);
    tb_pixel_model  tb_pixel_model_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic send_pixel(input int x, input int y);
        pixel_valid = 1'b1;
        draw_x      = coord_t'(x);
        draw_y      = coord_t'(y);
        @(negedge clk);
    endtask

    task automatic sweep_box(input int x0, input int y0, input int w, input int h,
                             input int step);
        for (int y = y0; y < y0 + h; y += step)
            for (int x = x0; x < x0 + w; x += step)
                send_pixel(x, y);
    endtask

    task automatic write_cell(input int row, input int col, input int color);
        cell_we    = 1'b1;
        cell_row   = cell_row_t'(row);
        cell_col   = cell_col_t'(col);
        cell_color = pal_idx_t'(color);
        @(negedge clk);
        cell_we    = 1'b0;
    endtask

    task automatic wait_valid(input logic level, input int limit);
        int n;
        n = 0;
        while (rgb_valid !== level && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (rgb_valid !== level)
        begin
            $display("Timeout: rgb_valid did not reach %0b within %0d cycles", level, limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input string name);
        pixel_valid = 1'b0;
        repeat (2) @(negedge clk);     // Pipeline depth
        wait_valid(1'b0, 8);
        tests_run++;
        $display("test %0d %s: %0d mismatches", tests_run, name, error_count - errors_before);
        errors_before = error_count;
    endtask

    task automatic run_tests();
        int r;
        int rx;
        int ry;
        int rc;

        // Quiet stream followed by a single pixel
        repeat (8) @(negedge clk);
        send_pixel(100, 50);
        pixel_valid = 1'b0;
        wait_valid(1'b1, 8);
        if (timed_out)
            return;
        end_test("valid latency");
        if (timed_out)
            return;

        for (int s = 0; s < 4; s++)
        begin
            game_state = game_state_e'(2'(s));
            for (int x = 0; x < 1024; x += 11)
            begin
                send_pixel(x, 40);
                send_pixel(x, 200);
            end
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    send_pixel(edge_x[i], edge_y[j]);
        end
        end_test("background gradients");
        if (timed_out)
            return;

        // ------------------------------
        // Playfield over the piece
        // ------------------------------
        game_state = gs_play;
        for (int i = 0; i < 10; i++)
            write_cell(2 * i, i, (i % 9) + 1);
        write_cell(19, 9, 7);
        write_cell(5, 4, 6);
        piece_shape = shape_o;
        piece_x     = coord_t'(298);   // Column 3, row 5
        piece_y     = coord_t'(180);
        sweep_box(242, 92, 176, 336, 8);
        end_test("playfield cells");
        if (timed_out)
            return;
        for (int i = 0; i < 10; i++)
            write_cell(2 * i, i, 0);
        write_cell(19, 9, 0);
        write_cell(5, 4, 0);

        piece_x = coord_t'(314);
        piece_y = coord_t'(212);
        for (int sh = 0; sh < 2; sh++)
        begin
            piece_shape = (sh == 0) ? shape_i : shape_o;
            for (int rot = 0; rot < 4; rot++)
            begin
                piece_rotation = rotation_t'(rot);
                sweep_box(306, 204, 80, 80, 8);
            end
        end
        end_test("I and O pieces");
        if (timed_out)
            return;

        piece_shape     = shape_none;
        score_thousands = 4'd0;
        score_hundreds  = 4'd1;
        score_tens      = 4'd0;
        score_ones      = 4'd1;
        sweep_box(488, 72, 100, 26, 2);
        end_test("score digits");
        if (timed_out)
            return;

        // ------------------------------
        // Random back-to-back stream
        // ------------------------------
        for (int i = 0; i < 2000; i++)
        begin
            r  = $random(seed);
            rx = $random(seed);
            ry = $random(seed);
            rc = $random(seed);
            if (r[3:0] == 4'd0)
            begin
                piece_shape    = (r[5:4] == 2'd0) ? shape_none :
                                 (r[5:4] == 2'd1) ? shape_i : shape_o;
                piece_rotation = r[7:6];
                piece_x        = coord_t'(200 + r[16:8]);
                piece_y        = coord_t'(60 + r[24:17]);
            end
            cell_we         = (r[27:25] == 3'd0);
            cell_row        = cell_row_t'(unsigned'(rc) % 20);
            cell_col        = cell_col_t'(unsigned'(rc) / 20 % 10);
            cell_color      = pal_idx_t'(unsigned'(rc) / 200 % 10);
            game_state      = game_state_e'(r[9:8]);
            score_thousands = digit_t'(r[28]);
            score_ones      = digit_t'(r[10]);
            pixel_valid     = (r[31:29] != 3'd0);   // Mostly back to back
            draw_x          = coord_t'(unsigned'(rx) % 640);
            draw_y          = coord_t'(unsigned'(ry) % 480);
            @(negedge clk);
        end
        cell_we = 1'b0;
        end_test("random stream");
    endtask

    initial
    begin
        reset           = 1'b1;
        pixel_valid     = 1'b0;
        draw_x          = '0;
        draw_y          = '0;
        game_state      = gs_play;
        piece_shape     = shape_none;
        piece_rotation  = '0;
        piece_x         = '0;
        piece_y         = '0;
        score_thousands = '0;
        score_hundreds  = '0;
        score_tens      = '0;
        score_ones      = '0;
        cell_we         = 1'b0;
        cell_row        = '0;
        cell_col        = '0;
        cell_color      = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        run_tests();

        $display("tests: %0d, checks: %0d, mismatches: %0d", tests_run, check_count, error_count);
        if (error_count == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tests/tb_pixel_model.sv ====
// Reference color model of the pixel mapper, compared with the DUT by assertions
`timescale 1ns/100ps

module tb_pixel_model
    import video_pkg::*;
    import tetris_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pixel_valid,
    input  coord_t      draw_x,
    input  coord_t      draw_y,
    input  game_state_e game_state,
    input  shape_e      piece_shape,
    input  rotation_t   piece_rotation,
    input  coord_t      piece_x,
    input  coord_t      piece_y,
    input  digit_t      score_thousands,
    input  digit_t      score_hundreds,
    input  digit_t      score_tens,
    input  digit_t      score_ones,
    input  logic        cell_we,
    input  cell_row_t   cell_row,
    input  cell_col_t   cell_col,
    input  pal_idx_t    cell_color,
    input  logic        rgb_valid,
    input  chan_t       red,
    input  chan_t       green,
    input  chan_t       blue,
    output int          error_count,
    output int          check_count
);

    pal_idx_t    board [200];    // Own copy of the playfield
    logic        valid_s1;
    logic        exp_valid;
    logic [23:0] rgb_s1;
    logic [23:0] exp_rgb;
    int          checks = 0;
    int          red_fails = 0;
    int          green_fails = 0;
    int          blue_fails = 0;
    int          valid_fails = 0;

    assign error_count = red_fails + green_fails + blue_fails + valid_fails;
    assign check_count = checks;

    function automatic logic [23:0] palette(input pal_idx_t idx);
        case (idx)
            4'd1:       return 24'h00FFFF;
            4'd2:       return 24'hFFFF00;
            4'd3:       return 24'h0000FF;
            4'd4:       return 24'hFFA500;
            4'd5:       return 24'h00FF00;
            4'd6:       return 24'hFF0000;
            4'd7:       return 24'h8A2BE2;
            4'd8, 4'd9: return 24'hFFFFFF;  // White
            default:    return 24'h000000;
        endcase
    endfunction

    // Only none, I and O are driven by the stimulus
    function automatic logic piece_cell(input shape_e sh, input rotation_t rot,
                                        input int r, input int c);
        case (sh)
            shape_o: return (r < 2) && (c < 2);              // Top-left 2x2
            shape_i: return rot[0] ? (c == 0) : (r == 0);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic digit_cell(input digit_t d, input int r, input int c);
        if (d == 4'd0)
            return (r == 0) || (r == 4) || (c == 0) || (c == 4);   // Outer ring
        if (d == 4'd1)
            return c == 2;
        return 1'b0;
    endfunction

    function automatic logic [23:0] expected_rgb();
        int       x;
        int       y;
        int       dx;
        int       dy;
        logic     inb;
        pal_idx_t pal;
        chan_t    g;
        digit_t   d [4];
        x    = int'(draw_x);
        y    = int'(draw_y);
        g    = chan_t'(x / 8);
        d[0] = score_thousands;
        d[1] = score_hundreds;
        d[2] = score_tens;
        d[3] = score_ones;
        inb  = (x >= 250) && (x < 410) && (y >= 100) && (y < 420);
        pal  = '0;
        if (inb)
            pal = board[8'(((y - 100) / 16) * 10 + (x - 250) / 16)];
        dx = x - int'(piece_x);
        dy = y - int'(piece_y);
        if (pal == '0 && piece_shape != shape_none && dx >= 0 && dx < 64 && dy >= 0 && dy < 64
            && piece_cell(piece_shape, piece_rotation, dy / 16, dx / 16))
            pal = 4'(int'(piece_shape));
        if (pal == '0 && y >= 75 && y < 95)
        begin
            for (int k = 0; k < 4; k++)
            begin
                dx = x - (492 + 24 * k);
                if (dx >= 0 && dx < 20 && digit_cell(d[k], (y - 75) / 4, dx / 4))
                    pal = 4'd9;
            end
        end
        if (game_state == gs_idle)
            return {8'h09 + g, 8'h04 + g, 8'h6A + g};     // Layers hidden
        if (pal != '0)
            return palette(pal);
        if (inb)
            return {3{8'h69 - g}};
        return {8'h00, 8'h47, 8'hAB - 8'(2 * (x / 8))};
    endfunction

    // ------------------------------
    // Two-stage expected pipeline
    // ------------------------------
    always @(posedge clk)
    begin
        if (reset)
        begin
            valid_s1  <= 1'b0;
            exp_valid <= 1'b0;
            for (int i = 0; i < 200; i++)
                board[8'(i)] = '0;
        end
        else
        begin
            valid_s1  <= pixel_valid;
            exp_valid <= valid_s1;
            rgb_s1    <= expected_rgb();   // Lookup sees the board before this write
            exp_rgb   <= rgb_s1;
            if (exp_valid)
                checks <= checks + 1;
            if (cell_we)
                board[8'(int'(cell_row) * 10 + int'(cell_col))] = cell_color;
        end
    end

    valid_match_a: assert property (@(posedge clk) disable iff (reset) rgb_valid == exp_valid)
        else begin
            $display("[FAIL] %0t rgb_valid: expected %0b got %0b",
                     $time, $sampled(exp_valid), $sampled(rgb_valid));
            valid_fails = valid_fails + 1;
        end

    red_match_a: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> red == exp_rgb[23:16])
        else begin
            $display("[FAIL] %0t red: expected %h got %h",
                     $time, $sampled(exp_rgb[23:16]), $sampled(red));
            red_fails = red_fails + 1;
        end

    green_match_a: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> green == exp_rgb[15:8])
        else begin
            $display("[FAIL] %0t green: expected %h got %h",
                     $time, $sampled(exp_rgb[15:8]), $sampled(green));
            green_fails = green_fails + 1;
        end

    blue_match_a: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> blue == exp_rgb[7:0])
        else begin
            $display("[FAIL] %0t blue: expected %h got %h",
                     $time, $sampled(exp_rgb[7:0]), $sampled(blue));
            blue_fails = blue_fails + 1;
        end

endmodule
